//--- hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

   localparam int xlen       = 32;
   localparam int reg_addr_w = 5;
   localparam logic [xlen-1:0] reset_pc = '0;

   // major opcodes
   localparam logic [6:0] opc_lui    = 7'b0110111;
   localparam logic [6:0] opc_auipc  = 7'b0010111;
   localparam logic [6:0] opc_jal    = 7'b1101111;
   localparam logic [6:0] opc_jalr   = 7'b1100111;
   localparam logic [6:0] opc_branch = 7'b1100011;
   localparam logic [6:0] opc_load   = 7'b0000011;
   localparam logic [6:0] opc_store  = 7'b0100011;
   localparam logic [6:0] opc_op_imm = 7'b0010011;
   localparam logic [6:0] opc_op     = 7'b0110011;

   typedef enum logic [2:0] {
      FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK, HALT
   } state_e;

   typedef enum logic [4:0] {
      OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
      OP_LW, OP_SW,
      OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
      OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
      OP_ILLEGAL
   } op_e;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } s_fmt_t;

   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
   } b_fmt_t;

   typedef struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } u_fmt_t;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } j_fmt_t;

   // one fetched word, seen through each encoding format
   typedef union packed {
      logic [31:0] raw;
      r_fmt_t      r;
      i_fmt_t      i;
      s_fmt_t      s;
      b_fmt_t      b;
      u_fmt_t      u;
      j_fmt_t      j;
   } instr_word_u;

   typedef struct packed {
      op_e                   op;
      logic [reg_addr_w-1:0] rd;
      logic [reg_addr_w-1:0] rs1;
      logic [reg_addr_w-1:0] rs2;
      logic [xlen-1:0]       imm;
   } decoded_t;

endpackage

`default_nettype wire

//--- hdl/mem_bus_if.sv
`default_nettype none

interface mem_bus_if;
   import rv_pkg::*;

   logic            req;
   logic            we;
   logic [xlen-1:0] addr;
   logic [xlen-1:0] wdata;
   logic            ack;
   logic [xlen-1:0] rdata;

   // four-phase: req up, ack up, req down, ack down
   modport requester (
      output req, we, addr, wdata,
      input  ack, rdata
   );

   modport responder (
      input  req, we, addr, wdata,
      output ack, rdata
   );

endinterface

`default_nettype wire

//--- hdl/decoder.sv
`default_nettype none

module decoder (
   input  logic                clk,
   input  logic                reset,
   input  rv_pkg::state_e      state,
   input  rv_pkg::instr_word_u instr,
   output rv_pkg::decoded_t    dec
);
   import rv_pkg::*;

   logic [6:0]      opcode;
   logic [2:0]      funct3;
   logic [6:0]      funct7;
   logic            fmt_r;
   logic            fmt_i;
   logic            fmt_s;
   logic            fmt_b;
   logic            fmt_u;
   logic            fmt_j;
   op_e             op;
   logic [xlen-1:0] imm;

   assign opcode = instr.r.opcode;
   assign funct3 = instr.r.funct3;
   assign funct7 = instr.r.funct7;

   assign fmt_r = (opcode == opc_op);
   assign fmt_i = (opcode inside {opc_jalr, opc_load, opc_op_imm});
   assign fmt_s = (opcode == opc_store);
   assign fmt_b = (opcode == opc_branch);
   assign fmt_u = (opcode inside {opc_lui, opc_auipc});
   assign fmt_j = (opcode == opc_jal);

   always_comb begin
      op = OP_ILLEGAL;
      case (opcode)
         opc_lui:    op = OP_LUI;
         opc_auipc:  op = OP_AUIPC;
         opc_jal:    op = OP_JAL;
         opc_jalr:   if (funct3 == 3'b000) op = OP_JALR;
         opc_load:   if (funct3 == 3'b010) op = OP_LW;
         opc_store:  if (funct3 == 3'b010) op = OP_SW;
         opc_branch: begin
            case (funct3)
               3'b000:  op = OP_BEQ;
               3'b001:  op = OP_BNE;
               3'b100:  op = OP_BLT;
               3'b101:  op = OP_BGE;
               3'b110:  op = OP_BLTU;
               3'b111:  op = OP_BGEU;
               default: op = OP_ILLEGAL;
            endcase
         end
         opc_op_imm: begin
            case (funct3)
               3'b000:  op = OP_ADDI;
               3'b010:  op = OP_SLTI;
               3'b011:  op = OP_SLTIU;
               3'b100:  op = OP_XORI;
               3'b110:  op = OP_ORI;
               3'b111:  op = OP_ANDI;
               3'b001:  if (funct7 == 7'b0000000) op = OP_SLLI;
               default: begin
                  // funct3 101, shift right kind is in funct7
                  if (funct7 == 7'b0000000) op = OP_SRLI;
                  else if (funct7 == 7'b0100000) op = OP_SRAI;
               end
            endcase
         end
         opc_op: begin
            case ({funct7, funct3})
               10'b0000000_000: op = OP_ADD;
               10'b0100000_000: op = OP_SUB;
               10'b0000000_001: op = OP_SLL;
               10'b0000000_010: op = OP_SLT;
               10'b0000000_011: op = OP_SLTU;
               10'b0000000_100: op = OP_XOR;
               10'b0000000_101: op = OP_SRL;
               10'b0100000_101: op = OP_SRA;
               10'b0000000_110: op = OP_OR;
               10'b0000000_111: op = OP_AND;
               default:         op = OP_ILLEGAL;
            endcase
         end
         default: op = OP_ILLEGAL;
      endcase
   end

   // sign-extended immediate per format
   always_comb begin
      if (fmt_i) imm = {{20{instr.i.imm[11]}}, instr.i.imm};
      else if (fmt_s) imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
      else if (fmt_b)
         imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11, instr.b.imm10_5,
                instr.b.imm4_1, 1'b0};
      else if (fmt_u) imm = {instr.u.imm, 12'b0};
      else if (fmt_j)
         imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12, instr.j.imm11,
                instr.j.imm10_1, 1'b0};
      else imm = '0;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         dec.op  <= OP_ILLEGAL;
         dec.rd  <= '0;
         dec.rs1 <= '0;
         dec.rs2 <= '0;
         dec.imm <= '0;
      end else if (state == DECODE) begin
         dec.op  <= op;
         dec.rd  <= (fmt_r || fmt_i || fmt_u || fmt_j) ? instr.r.rd : '0;
         dec.rs1 <= (fmt_r || fmt_i || fmt_s || fmt_b) ? instr.r.rs1 : '0;
         dec.rs2 <= (fmt_r || fmt_s || fmt_b) ? instr.r.rs2 : '0;
         dec.imm <= imm;
      end
   end

   // stores and branches must never reach writeback with a live rd
   assert property (@(posedge clk) disable iff (reset)
      (dec.op inside {OP_SW, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU})
      |-> (dec.rd == '0));

endmodule

`default_nettype wire

//--- hdl/regfile.sv
`default_nettype none

module regfile (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [rv_pkg::reg_addr_w-1:0] rs1,
   input  logic [rv_pkg::reg_addr_w-1:0] rs2,
   output logic [rv_pkg::xlen-1:0]       rdata1,
   output logic [rv_pkg::xlen-1:0]       rdata2,
   input  logic                          we,
   input  logic [rv_pkg::reg_addr_w-1:0] rd,
   input  logic [rv_pkg::xlen-1:0]       wdata
);
   import rv_pkg::*;

   // x0 has no storage
   logic [xlen-1:0] regs [1:31];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && rd != '0) begin
         regs[rd] <= wdata;
      end
   end

   assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
   assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- hdl/core_ctrl.sv
`default_nettype none

module core_ctrl (
   input  logic         clk,
   input  logic         reset,
   mem_bus_if.requester fetch_bus,
   mem_bus_if.requester data_bus,
   output logic         halted
);
   import rv_pkg::*;

   state_e          state;
   logic [xlen-1:0] pc;
   instr_word_u     ir;
   logic [xlen-1:0] alu_res;
   logic [xlen-1:0] load_data;
   logic            fetch_req;
   logic            data_req;
   logic            acked;
   decoded_t        dec;
   logic [xlen-1:0] rs1_val;
   logic [xlen-1:0] rs2_val;
   logic [xlen-1:0] op_b;
   logic [4:0]      shamt;
   logic [xlen-1:0] alu_out;
   logic            taken;
   logic [xlen-1:0] next_pc;
   logic            rf_we;
   logic [xlen-1:0] rf_wdata;

   decoder decoder_i (
      .clk   (clk),
      .reset (reset),
      .state (state),
      .instr (ir),
      .dec   (dec)
   );

   regfile regfile_i (
      .clk    (clk),
      .reset  (reset),
      .rs1    (dec.rs1),
      .rs2    (dec.rs2),
      .rdata1 (rs1_val),
      .rdata2 (rs2_val),
      .we     (rf_we),
      .rd     (dec.rd),
      .wdata  (rf_wdata)
   );

   // register ops take rs2, everything else the immediate
   assign op_b = (dec.op inside {OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
                                 OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND}) ? rs2_val : dec.imm;
   assign shamt = op_b[4:0];

   always_comb begin
      case (dec.op)
         OP_LUI:            alu_out = dec.imm;
         OP_AUIPC:          alu_out = pc + dec.imm;
         OP_JAL, OP_JALR:   alu_out = pc + 32'd4;
         OP_SUB:            alu_out = rs1_val - op_b;
         OP_SLT, OP_SLTI:   alu_out = {{(xlen-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
         OP_SLTU, OP_SLTIU: alu_out = {{(xlen-1){1'b0}}, rs1_val < op_b};
         OP_XOR, OP_XORI:   alu_out = rs1_val ^ op_b;
         OP_OR, OP_ORI:     alu_out = rs1_val | op_b;
         OP_AND, OP_ANDI:   alu_out = rs1_val & op_b;
         OP_SLL, OP_SLLI:   alu_out = rs1_val << shamt;
         OP_SRL, OP_SRLI:   alu_out = rs1_val >> shamt;
         OP_SRA, OP_SRAI:   alu_out = $unsigned($signed(rs1_val) >>> shamt);
         default:           alu_out = rs1_val + op_b;
      endcase
   end

   always_comb begin
      case (dec.op)
         OP_BEQ:  taken = (rs1_val == rs2_val);
         OP_BNE:  taken = (rs1_val != rs2_val);
         OP_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
         OP_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
         OP_BLTU: taken = (rs1_val < rs2_val);
         OP_BGEU: taken = (rs1_val >= rs2_val);
         OP_JAL:  taken = 1'b1;
         default: taken = 1'b0;
      endcase
   end

   assign next_pc = (dec.op == OP_JALR) ? ((rs1_val + dec.imm) & ~32'd1) :
                    taken ? (pc + dec.imm) : (pc + 32'd4);

   assign fetch_bus.req   = fetch_req;
   assign fetch_bus.we    = 1'b0;
   assign fetch_bus.addr  = pc;
   assign fetch_bus.wdata = '0;
   assign data_bus.req    = data_req;
   assign data_bus.we     = (dec.op == OP_SW);
   assign data_bus.addr   = alu_res;
   assign data_bus.wdata  = rs2_val;

   // rd is already zero for stores and branches
   assign rf_we    = (state == WRITEBACK);
   assign rf_wdata = (dec.op == OP_LW) ? load_data : alu_res;
   assign halted   = (state == HALT);

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= FETCH;
         pc        <= reset_pc;
         fetch_req <= 1'b0;
         data_req  <= 1'b0;
         acked     <= 1'b0;
      end else begin
         case (state)
            FETCH: begin
               if (!fetch_req && !acked && !fetch_bus.ack) begin
                  fetch_req <= 1'b1;
               end else if (fetch_req && fetch_bus.ack) begin
                  fetch_req <= 1'b0;
                  acked     <= 1'b1;
               end else if (acked && !fetch_bus.ack) begin
                  acked <= 1'b0;
                  state <= DECODE;
               end
            end
            DECODE: state <= EXECUTE;
            EXECUTE: begin
               if (dec.op == OP_ILLEGAL) begin
                  state <= HALT;
               end else begin
                  pc    <= next_pc;
                  state <= (dec.op inside {OP_LW, OP_SW}) ? MEMORY : WRITEBACK;
               end
            end
            MEMORY: begin
               if (!data_req && !acked && !data_bus.ack) begin
                  data_req <= 1'b1;
               end else if (data_req && data_bus.ack) begin
                  data_req <= 1'b0;
                  acked    <= 1'b1;
               end else if (acked && !data_bus.ack) begin
                  acked <= 1'b0;
                  state <= WRITEBACK;
               end
            end
            WRITEBACK: state <= FETCH;
            HALT:      state <= HALT;
            default:   state <= HALT;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == FETCH && fetch_req && fetch_bus.ack) ir.raw <= fetch_bus.rdata;
      if (state == MEMORY && data_req && data_bus.ack) load_data <= data_bus.rdata;
      if (state == EXECUTE) alu_res <= alu_out;
   end

   assert property (@(posedge clk) disable iff (reset) !(fetch_bus.req && data_bus.req));

   assert property (@(posedge clk) disable iff (reset)
      fetch_bus.req |=> (!fetch_bus.req || $stable(fetch_bus.addr)));

   assert property (@(posedge clk) disable iff (reset)
      data_bus.req |=> (!data_bus.req || $stable(data_bus.addr)));

endmodule

`default_nettype wire

//--- hdl/mem_arbiter.sv
`default_nettype none

module mem_arbiter (
   input  logic                    clk,
   input  logic                    reset,
   mem_bus_if.responder            fetch_bus,
   mem_bus_if.responder            data_bus,
   output logic                    mem_req,
   output logic                    mem_we,
   output logic [rv_pkg::xlen-1:0] mem_addr,
   output logic [rv_pkg::xlen-1:0] mem_wdata,
   input  logic                    mem_ack,
   input  logic [rv_pkg::xlen-1:0] mem_rdata
);

   // high selects load/store
   logic grant;

   // re-arbitrate only with the shared port fully idle
   always_ff @(posedge clk) begin
      if (reset) begin
         grant <= 1'b0;
      end else if (!mem_req && !mem_ack) begin
         if (data_bus.req) grant <= 1'b1;
         else if (fetch_bus.req) grant <= 1'b0;
      end
   end

   assign mem_req   = grant ? data_bus.req   : fetch_bus.req;
   assign mem_we    = grant ? data_bus.we    : fetch_bus.we;
   assign mem_addr  = grant ? data_bus.addr  : fetch_bus.addr;
   assign mem_wdata = grant ? data_bus.wdata : fetch_bus.wdata;

   assign fetch_bus.ack   = !grant && mem_ack;
   assign fetch_bus.rdata = grant ? '0 : mem_rdata;
   assign data_bus.ack    = grant && mem_ack;
   assign data_bus.rdata  = grant ? mem_rdata : '0;

   assert property (@(posedge clk) disable iff (reset)
      (mem_req || mem_ack) |=> $stable(grant));

endmodule

`default_nettype wire

//--- hdl/rv_core_top.sv
`default_nettype none

module rv_core_top (
   input  logic                    clk,
   input  logic                    reset,
   output logic                    mem_req,
   output logic                    mem_we,
   output logic [rv_pkg::xlen-1:0] mem_addr,
   output logic [rv_pkg::xlen-1:0] mem_wdata,
   input  logic                    mem_ack,
   input  logic [rv_pkg::xlen-1:0] mem_rdata,
   output logic                    halted
);

   mem_bus_if fetch_bus ();
   mem_bus_if data_bus ();

   core_ctrl core_ctrl_i (
      .clk       (clk),
      .reset     (reset),
      .fetch_bus (fetch_bus),
      .data_bus  (data_bus),
      .halted    (halted)
   );

   // single external port shared by fetch and load/store
   mem_arbiter mem_arbiter_i (
      .clk       (clk),
      .reset     (reset),
      .fetch_bus (fetch_bus),
      .data_bus  (data_bus),
      .mem_req   (mem_req),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata)
   );

endmodule

`default_nettype wire

//--- testbench/tb_rv_core.sv
`default_nettype none

module tb_rv_core;
   timeunit 1ns;
   timeprecision 100ps;
   import rv_pkg::*;

   localparam int max_cycles = 10000;
   localparam logic [31:0] c1 = 32'h12345678;
   localparam logic [31:0] c2 = 32'hFFFFFFFD;
   localparam logic [31:0] c3 = 32'd5;
   localparam logic [31:0] res_base = 32'h1000;
   localparam logic [31:0] data_addr = 32'h17FC;
   localparam logic [31:0] data_word = 32'hCAFE0123;

   logic        clk;
   logic        reset;
   logic        mem_req;
   logic        mem_we;
   logic [31:0] mem_addr;
   logic [31:0] mem_wdata;
   logic        mem_ack;
   logic [31:0] mem_rdata;
   logic        halted;

   logic [31:0] mem [0:2047];
   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];
   logic [31:0] halt_addr;
   logic [31:0] last_read;
   int          pc_w = 0;
   int          res_off = 0;
   int          mark_n = 0;
   int          nstores = 0;
   int          value_errors = 0;
   int          proto_errors = 0;
   int          wait_n;
   int          cycles;

   rv_core_top rv_core_top_i (
      .clk       (clk),
      .reset     (reset),
      .mem_req   (mem_req),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata),
      .halted    (halted)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   function automatic logic [31:0] r_type(input int f7, input int f3, input int rd,
                                          input int rs1, input int rs2);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_op};
   endfunction

   function automatic logic [31:0] i_type(input logic [6:0] opc, input int f3, input int rd,
                                          input int rs1, input int imm);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
   endfunction

   function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opc_store};
   endfunction

   function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                          input int imm);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opc_branch};
   endfunction

   function automatic logic [31:0] u_type(input logic [6:0] opc, input int rd, input int imm);
      return {imm[19:0], rd[4:0], opc};
   endfunction

   function automatic logic [31:0] j_type(input int rd, input int imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal};
   endfunction

   // branch outcome straight from the ISA definition
   function automatic logic branch_taken(input int f3, input logic [31:0] a, input logic [31:0] b);
      case (f3)
         0:       return a == b;
         1:       return a != b;
         4:       return $signed(a) < $signed(b);
         5:       return $signed(a) >= $signed(b);
         6:       return a < b;
         default: return a >= b;
      endcase
   endfunction

   task automatic put(input logic [31:0] word);
      mem[pc_w] = word;
      pc_w++;
   endtask

   task automatic store_result(input int rs2, input logic [31:0] value);
      put(s_type(rs2, 10, res_off));
      exp_addr.push_back(res_base + res_off);
      exp_data.push_back(value);
      res_off += 4;
   endtask

   task automatic alu_case(input logic [31:0] word, input logic [31:0] value);
      put(word);
      store_result(4, value);
   endtask

   // the skipped slot would overwrite the marker in x5
   task automatic branch_case(input int f3, input int rs1, input int rs2,
                              input logic [31:0] a, input logic [31:0] b);
      int taken_mark;
      int fall_mark;
      taken_mark = 'h100 + mark_n;
      fall_mark = 'h200 + mark_n;
      mark_n++;
      put(i_type(opc_op_imm, 0, 5, 0, taken_mark));
      put(b_type(f3, rs1, rs2, 8));
      put(i_type(opc_op_imm, 0, 5, 0, fall_mark));
      store_result(5, branch_taken(f3, a, b) ? taken_mark : fall_mark);
   endtask

   task automatic build_program();
      logic [31:0] a;
      for (int i = 0; i < 2048; i++) begin
         mem[i] = (i * 4) ^ 32'h5EED0000;
      end
      mem[data_addr[12:2]] = data_word;
      put(u_type(opc_lui, 1, 'h12345));
      put(i_type(opc_op_imm, 0, 1, 1, 'h678));
      put(i_type(opc_op_imm, 0, 2, 0, -3));
      put(i_type(opc_op_imm, 0, 3, 0, 5));
      put(u_type(opc_lui, 10, 1));
      store_result(1, c1);
      a = pc_w * 4;
      alu_case(u_type(opc_auipc, 4, 'h10), a + 32'h10000);
      alu_case(i_type(opc_op_imm, 0, 4, 2, -100), c2 + 32'hFFFFFF9C);
      alu_case(i_type(opc_op_imm, 2, 4, 2, 1), {31'b0, $signed(c2) < 1});
      alu_case(i_type(opc_op_imm, 3, 4, 3, -1), {31'b0, c3 < 32'hFFFFFFFF});
      alu_case(i_type(opc_op_imm, 4, 4, 1, -1), ~c1);
      alu_case(i_type(opc_op_imm, 6, 4, 1, 'h0F0), c1 | 32'h0F0);
      alu_case(i_type(opc_op_imm, 7, 4, 1, -16), c1 & 32'hFFFFFFF0);
      alu_case(i_type(opc_op_imm, 1, 4, 1, 4), c1 << 4);
      alu_case(i_type(opc_op_imm, 5, 4, 2, 4), c2 >> 4);
      alu_case(i_type(opc_op_imm, 5, 4, 2, 'h404), 32'($signed(c2) >>> 4));
      alu_case(r_type(0, 0, 4, 1, 2), c1 + c2);
      alu_case(r_type('h20, 0, 4, 1, 2), c1 - c2);
      alu_case(r_type(0, 1, 4, 1, 3), c1 << c3[4:0]);
      alu_case(r_type(0, 2, 4, 2, 3), {31'b0, $signed(c2) < $signed(c3)});
      alu_case(r_type(0, 3, 4, 2, 3), {31'b0, c2 < c3});
      alu_case(r_type(0, 4, 4, 1, 2), c1 ^ c2);
      alu_case(r_type(0, 5, 4, 2, 3), c2 >> c3[4:0]);
      alu_case(r_type('h20, 5, 4, 2, 3), 32'($signed(c2) >>> c3[4:0]));
      alu_case(r_type(0, 6, 4, 1, 2), c1 | c2);
      alu_case(r_type(0, 7, 4, 1, 2), c1 & c2);
      // each kind once taken and once not
      branch_case(0, 3, 3, c3, c3);
      branch_case(0, 3, 1, c3, c1);
      branch_case(1, 3, 1, c3, c1);
      branch_case(1, 3, 3, c3, c3);
      branch_case(4, 2, 3, c2, c3);
      branch_case(4, 3, 2, c3, c2);
      branch_case(5, 3, 2, c3, c2);
      branch_case(5, 2, 3, c2, c3);
      branch_case(6, 3, 2, c3, c2);
      branch_case(6, 2, 3, c2, c3);
      branch_case(7, 2, 3, c2, c3);
      branch_case(7, 3, 2, c3, c2);
      a = pc_w * 4;
      put(j_type(6, 8));
      put(i_type(opc_op_imm, 0, 6, 0, -1));
      store_result(6, a + 4);
      // odd jalr offset drops bit 0 of the target
      a = pc_w * 4;
      put(u_type(opc_auipc, 7, 0));
      put(i_type(opc_jalr, 0, 8, 7, 13));
      put(i_type(opc_op_imm, 0, 8, 0, -1));
      store_result(8, a + 8);
      store_result(7, a);
      put(i_type(opc_load, 2, 9, 10, data_addr - res_base));
      put(i_type(opc_op_imm, 0, 9, 9, 'h111));
      store_result(9, data_word + 32'h111);
      halt_addr = pc_w * 4;
      put(32'h0);
   endtask

   task automatic check_store();
      if (nstores >= exp_addr.size()) begin
         value_errors++;
         $display("store beyond the expected table, address %h", mem_addr);
      end else begin
         assert (mem_addr == exp_addr[nstores]) else begin
            value_errors++;
            $display("FAILED mem_addr: got %h expected %h", mem_addr, exp_addr[nstores]);
         end
         assert (mem_wdata == exp_data[nstores]) else begin
            value_errors++;
            $display("FAILED mem_wdata: got %h expected %h at %h",
                     mem_wdata, exp_data[nstores], mem_addr);
         end
      end
      nstores++;
   endtask

   // memory responder with random ack delay and random ack release
   initial begin
      void'($urandom(76));
      forever begin
         @(negedge clk);
         if (!reset && mem_req && !mem_ack) begin
            repeat ($urandom_range(4, 1)) @(negedge clk);
            if (mem_we) begin
               check_store();
               mem[mem_addr[12:2]] = mem_wdata;
            end else begin
               mem_rdata = mem[mem_addr[12:2]];
               last_read = mem_addr;
            end
            mem_ack = 1'b1;
            wait_n = 0;
            while (mem_req && wait_n < 64) begin
               @(negedge clk);
               wait_n++;
            end
            if (mem_req) begin
               proto_errors++;
               $display("mem_req still high %0d cycles after ack", wait_n);
            end
            // ack may linger after req falls
            repeat ($urandom_range(3, 0)) @(negedge clk);
            mem_ack = 1'b0;
         end
      end
   end

   assert property (@(posedge clk) disable iff (reset)
      mem_req |=> (!mem_req || ($stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata))))
   else begin
      proto_errors++;
      $display("address, we or wdata changed while mem_req was high");
   end

   assert property (@(posedge clk) disable iff (reset) (mem_req && !mem_ack) |=> mem_req)
   else begin
      proto_errors++;
      $display("mem_req dropped before ack");
   end

   assert property (@(posedge clk) disable iff (reset) $rose(mem_req) |-> !mem_ack)
   else begin
      proto_errors++;
      $display("new mem_req raised while ack was still high");
   end

   assert property (@(posedge clk) disable iff (reset) halted |-> !mem_req)
   else begin
      proto_errors++;
      $display("memory request issued after halt");
   end

   initial begin
      reset = 1'b1;
      mem_ack = 1'b0;
      mem_rdata = '0;
      last_read = '0;
      build_program();
      repeat (10) @(negedge clk);
      reset = 1'b0;
      assert (mem_req == 1'b0) else begin
         value_errors++;
         $display("FAILED mem_req after reset: got %h expected 0", mem_req);
      end
      assert (halted == 1'b0) else begin
         value_errors++;
         $display("FAILED halted after reset: got %h expected 0", halted);
      end
      cycles = 0;
      while (!halted && cycles < max_cycles) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) begin
         proto_errors++;
         $display("timeout, core never halted within %0d cycles", max_cycles);
      end
      // idle window to catch stray requests after halt
      repeat (20) @(negedge clk);
      assert (last_read == halt_addr) else begin
         value_errors++;
         $display("FAILED last fetch addr: got %h expected %h", last_read, halt_addr);
      end
      assert (nstores == exp_addr.size()) else begin
         value_errors++;
         $display("FAILED store count: got %h expected %h", nstores, exp_addr.size());
      end
      $display("summary: %0d value errors, %0d protocol errors, %0d of %0d stores",
               value_errors, proto_errors, nstores, exp_addr.size());
      if (value_errors == 0 && proto_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
hdl/rv_pkg.sv
hdl/mem_bus_if.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/core_ctrl.sv
hdl/mem_arbiter.sv
hdl/rv_core_top.sv
testbench/tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
   --top-module tb_rv_core -f project.f -o tb_rv_core
./obj_dir/tb_rv_core > sim.log 2>&1 || true
cat sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
   echo "simulation ok"
else
   echo "simulation reported errors"
   exit 1
fi
